// File: compile.f
hdl/pwm_pkg.sv
hdl/pwm_job_if.sv
hdl/coef_mult_reduce.sv
hdl/mod_add_sub.sv
hdl/karatsuba_pairwm.sv
hdl/pwm_apb_regs.sv
hdl/pwm_top.sv
tb/tb_pwm_top.sv

// File: tb/tb_pwm_top.sv
// testbench for the pairwise multiplier subsystem
// drives apb jobs into pwm_top, concurrent assertions check every read and error flag
`timescale 1ns/10ps
`default_nettype none

module tb_pwm_top
    import pwm_pkg::*;
();

    // status polls allowed per job before giving up
    localparam int POLL_LIMIT = 20;

    logic      clk;
    logic      reset_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    // expectations seen by the assertions
    logic      chk_rd;
    apb_data_t exp_rdata;
    logic      exp_slverr;
    apb_data_t rd_capture;
    int        errors;

    pwm_top u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #20 clk = ~clk;

    // read data taken at the edge that closes the access phase
    always @(posedge clk) begin
        if (psel && penable && !pwrite) begin
            rd_capture <= prdata;
        end
    end

    // ------------------------------
    // checking assertions
    // ------------------------------
    a_result: assert property (@(posedge clk) disable iff (!reset_n)
        psel && penable && !pwrite && chk_rd && paddr == REG_RESULT |-> prdata == exp_rdata)
        else begin
            errors++;
            $display("[ERROR] prdata_o RESULT got=%h exp=%h", $sampled(prdata), exp_rdata);
        end

    a_readback: assert property (@(posedge clk) disable iff (!reset_n)
        psel && penable && !pwrite && chk_rd && paddr != REG_RESULT |-> prdata == exp_rdata)
        else begin
            errors++;
            $display("[ERROR] prdata_o addr=%h got=%h exp=%h",
                     $sampled(paddr), $sampled(prdata), exp_rdata);
        end

    a_slverr: assert property (@(posedge clk) disable iff (!reset_n)
        psel && penable |-> pslverr == exp_slverr)
        else begin
            errors++;
            $display("[ERROR] pslverr_o addr=%h got=%h exp=%h",
                     $sampled(paddr), $sampled(pslverr), exp_slverr);
        end

    // no wait states, ready follows select
    a_ready: assert property (@(posedge clk) disable iff (!reset_n) psel |-> pready)
        else begin
            errors++;
            $display("[ERROR] pready_o got=%h exp=%h", $sampled(pready), 1'b1);
        end

    // bus outputs stay quiet between accesses, from reset on
    a_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !psel |-> !pslverr && prdata == '0)
        else begin
            errors++;
            $display("[ERROR] idle bus pslverr_o=%h prdata_o=%h",
                     $sampled(pslverr), $sampled(prdata));
        end

    // ------------------------------
    // reference model
    // ------------------------------
    // element 0 in bits 11:0, element 1 in bits 27:16
    function automatic apb_data_t pair_word(input int e0, input int e1);
        apb_data_t word;
        word        = '0;
        word[11:0]  = e0[11:0];
        word[27:16] = e1[11:0];
        return word;
    endfunction

    function automatic apb_data_t model_result(input int a0, input int a1, input int b0,
                                               input int b1, input int w0, input int w1,
                                               input int zeta, input bit acc);
        longint c0;
        longint c1;
        c0 = longint'(a0) * b0 + longint'(a1) * b1 * zeta;
        c1 = (longint'(a0) + a1) * (longint'(b0) + b1) - longint'(a0) * b0 -
             longint'(a1) * b1;
        if (acc) begin
            c0 = c0 + w0;
            c1 = c1 + w1;
        end
        c0 = ((c0 % 3329) + 3329) % 3329;
        c1 = ((c1 % 3329) + 3329) % 3329;
        return pair_word(int'(c0), int'(c1));
    endfunction

    function automatic int rand_coef();
        return int'($urandom % 3329);
    endfunction

    // operand k of corner pattern sel is either 0 or q-1
    function automatic int corner_val(input int sel, input int k);
        return ((sel >> k) & 1) ? 3328 : 0;
    endfunction

    // ------------------------------
    // apb tasks, entered and left on a falling edge
    // ------------------------------
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input bit exp_err);
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = 1'b1;
        paddr      = addr;
        pwdata     = data;
        exp_slverr = exp_err;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        exp_slverr = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, input bit exp_err);
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = addr;
        exp_slverr = exp_err;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        data       = rd_capture;
        psel       = 1'b0;
        penable    = 1'b0;
        exp_slverr = 1'b0;
    endtask

    // read with the value armed for the assertions
    task automatic check_read(input apb_addr_t addr, input apb_data_t exp);
        apb_data_t dummy;
        chk_rd    = 1'b1;
        exp_rdata = exp;
        apb_read(addr, dummy, 1'b0);
        chk_rd = 1'b0;
    endtask

    task automatic wait_done();
        apb_data_t st;
        int        polls;
        bit        seen;
        polls = 0;
        seen  = 1'b0;
        while (!seen && polls < POLL_LIMIT) begin
            apb_read(REG_STATUS, st, 1'b0);
            seen  = st[STAT_DONE];
            polls = polls + 1;
        end
        if (!seen) begin
            errors++;
            $display("timeout, done never set after %0d status polls", polls);
            $display("errors: %0d", errors);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    // ------------------------------
    // job sequences
    // ------------------------------
    task automatic load_job(input int a0, input int a1, input int b0, input int b1,
                            input int w0, input int w1, input int zeta);
        apb_write(REG_A, pair_word(a0, a1), 1'b0);
        apb_write(REG_B, pair_word(b0, b1), 1'b0);
        apb_write(REG_W, pair_word(w0, w1), 1'b0);
        apb_write(REG_ZETA, pair_word(zeta, 0), 1'b0);
    endtask

    task automatic start_job(input bit acc, input bit exp_err);
        apb_write(REG_CTRL, (32'(acc) << CTRL_ACC) | (32'd1 << CTRL_START), exp_err);
    endtask

    // done then result then done cleared on the next status read
    task automatic finish_job(input apb_data_t exp_res);
        wait_done();
        check_read(REG_STATUS, 32'd1 << STAT_DONE);
        check_read(REG_RESULT, exp_res);
        check_read(REG_STATUS, '0);
    endtask

    task automatic run_job(input int a0, input int a1, input int b0, input int b1,
                           input int w0, input int w1, input int zeta, input bit acc);
        load_job(a0, a1, b0, b1, w0, w1, zeta);
        start_job(acc, 1'b0);
        finish_job(model_result(a0, a1, b0, b1, w0, w1, zeta, acc));
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        chk_rd     = 1'b0;
        exp_rdata  = '0;
        exp_slverr = 1'b0;
        rd_capture = '0;
        errors     = 0;
        void'($urandom(99));

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // quiet after reset
        check_read(REG_STATUS, '0);
        check_read(REG_RESULT, '0);

        // plain random jobs
        for (int i = 0; i < 40; i++) begin
            run_job(rand_coef(), rand_coef(), rand_coef(), rand_coef(),
                    rand_coef(), rand_coef(), rand_coef(), 1'b0);
        end

        // accumulated random jobs
        for (int i = 0; i < 20; i++) begin
            run_job(rand_coef(), rand_coef(), rand_coef(), rand_coef(),
                    rand_coef(), rand_coef(), rand_coef(), 1'b1);
        end

        // every 0 / q-1 mix of the seven operands, bit 7 picks accumulate
        for (int sel = 0; sel < 256; sel++) begin
            run_job(corner_val(sel, 0), corner_val(sel, 1), corner_val(sel, 2),
                    corner_val(sel, 3), corner_val(sel, 4), corner_val(sel, 5),
                    corner_val(sel, 6), sel[7]);
        end

        // ------------------------------
        // bus errors during a running job
        // ------------------------------
        load_job(1234, 77, 3000, 5, 900, 901, 17);
        start_job(1'b0, 1'b0);
        // second start refused while the first job is in flight
        start_job(1'b1, 1'b1);
        apb_write(8'h40, 32'hDEAD_BEEF, 1'b1);
        finish_job(model_result(1234, 77, 3000, 5, 900, 901, 17, 1'b0));

        // ------------------------------
        // zeroize clears results and operands
        // ------------------------------
        load_job(1, 2, 3, 4, 6, 7, 5);
        start_job(1'b0, 1'b0);
        // busy shows while the job is still in the pipeline
        check_read(REG_STATUS, 32'd1 << STAT_BUSY);
        wait_done();
        check_read(REG_A, pair_word(1, 2));
        apb_write(REG_CTRL, 32'd1 << CTRL_ZERO, 1'b0);
        check_read(REG_STATUS, '0);
        check_read(REG_RESULT, '0);
        check_read(REG_A, '0);
        check_read(REG_B, '0);
        check_read(REG_W, '0);
        check_read(REG_ZETA, '0);

        repeat (2) @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/pwm_top.sv
// top level of the pairwise multiplier subsystem
// apb ports in, register file and karatsuba pipeline joined by the job interface
`timescale 1ns/10ps
`default_nettype none

module pwm_top
    import pwm_pkg::*;
(
    input  wire            clk,
    input  wire            reset_n,

    // apb slave
    input  wire            psel_i,
    input  wire            penable_i,
    input  wire            pwrite_i,
    input  wire apb_addr_t paddr_i,
    input  wire apb_data_t pwdata_i,
    output apb_data_t      prdata_o,
    output logic           pready_o,
    output logic           pslverr_o
);

    // job channel between register file and pipeline
    pwm_job_if u_job ();

    // ------------------------------
    // register front end
    // ------------------------------
    pwm_apb_regs u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .job       (u_job.regs)
    );

    // ------------------------------
    // multiply pipeline
    // ------------------------------
    karatsuba_pairwm u_pipe (
        .clk     (clk),
        .reset_n (reset_n),
        .job     (u_job.pipe)
    );

endmodule

`default_nettype wire

// File: hdl/pwm_apb_regs.sv
// apb slave for the pairwise multiplier
// holds operands, control and status, issues jobs and captures results
// every access is setup plus access phase, no wait states
`timescale 1ns/10ps
`default_nettype none

module pwm_apb_regs
    import pwm_pkg::*;
(
    input  wire            clk,
    input  wire            reset_n,
    input  wire            psel_i,
    input  wire            penable_i,
    input  wire            pwrite_i,
    input  wire apb_addr_t paddr_i,
    input  wire apb_data_t pwdata_i,
    output apb_data_t      prdata_o,
    output logic           pready_o,
    output logic           pslverr_o,
    pwm_job_if.regs        job
);

    typedef enum logic [1:0] {
        JOB_IDLE,
        JOB_BUSY,
        JOB_DONE
    } job_state_t;

    job_state_t state;
    logic       wr_access;
    logic       rd_access;
    logic       addr_mapped;
    logic       start_err;
    logic       ctrl_ok;
    coef_t      c0_q;
    coef_t      c1_q;
    apb_data_t  rdata;

    // pack two elements into one register word
    function automatic apb_data_t pack_pair(coef_t e0, coef_t e1);
        apb_data_t word;
        word                         = '0;
        word[0 +: COEF_W]            = e0;
        word[ELEM1_LSB +: COEF_W]    = e1;
        return word;
    endfunction

    // ------------------------------
    // decode
    // ------------------------------
    assign wr_access = psel_i & penable_i & pwrite_i;
    assign rd_access = psel_i & penable_i & ~pwrite_i;

    always_comb begin
        case (paddr_i)
            REG_A, REG_B, REG_W, REG_ZETA,
            REG_CTRL, REG_STATUS, REG_RESULT: addr_mapped = 1'b1;
            default:                          addr_mapped = 1'b0;
        endcase
    end

    // a second start while a job runs is refused
    assign start_err = wr_access & (paddr_i == REG_CTRL) & pwdata_i[CTRL_START] &
                       (state == JOB_BUSY);
    assign ctrl_ok   = wr_access & (paddr_i == REG_CTRL) & ~start_err;

    assign pready_o  = psel_i;
    assign pslverr_o = psel_i & penable_i & (~addr_mapped | start_err);

    // ------------------------------
    // operand registers
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            {job.a0, job.a1, job.b0, job.b1} <= '0;
            {job.w0, job.w1, job.zeta}       <= '0;
        end else if (job.zeroize) begin
            {job.a0, job.a1, job.b0, job.b1} <= '0;
            {job.w0, job.w1, job.zeta}       <= '0;
        end else if (wr_access) begin
            case (paddr_i)
                REG_A: begin
                    job.a0 <= pwdata_i[0 +: COEF_W];
                    job.a1 <= pwdata_i[ELEM1_LSB +: COEF_W];
                end
                REG_B: begin
                    job.b0 <= pwdata_i[0 +: COEF_W];
                    job.b1 <= pwdata_i[ELEM1_LSB +: COEF_W];
                end
                REG_W: begin
                    job.w0 <= pwdata_i[0 +: COEF_W];
                    job.w1 <= pwdata_i[ELEM1_LSB +: COEF_W];
                end
                REG_ZETA: job.zeta <= pwdata_i[0 +: COEF_W];
                default: ;
            endcase
        end
    end

    // ------------------------------
    // job control and result capture
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= JOB_IDLE;
            job.valid      <= 1'b0;
            job.zeroize    <= 1'b0;
            job.accumulate <= 1'b0;
            c0_q           <= '0;
            c1_q           <= '0;
        end else begin
            // zeroize is a single pulse after the ctrl write
            job.zeroize <= ctrl_ok & pwdata_i[CTRL_ZERO];
            if (job.zeroize) begin
                state          <= JOB_IDLE;
                job.valid      <= 1'b0;
                job.accumulate <= 1'b0;
                c0_q           <= '0;
                c1_q           <= '0;
            end else begin
                job.valid <= ctrl_ok & pwdata_i[CTRL_START] & ~pwdata_i[CTRL_ZERO];
                if (ctrl_ok) begin
                    job.accumulate <= pwdata_i[CTRL_ACC];
                end
                // no back-pressure, the result is always taken
                if (job.res_valid) begin
                    c0_q <= job.c0;
                    c1_q <= job.c1;
                end
                if (ctrl_ok && pwdata_i[CTRL_START] && !pwdata_i[CTRL_ZERO]) begin
                    state <= JOB_BUSY;
                end else if (state == JOB_BUSY && job.res_valid) begin
                    state <= JOB_DONE;
                end else if (state == JOB_DONE && rd_access && paddr_i == REG_RESULT) begin
                    state <= JOB_IDLE;
                end
            end
        end
    end

    // read mux
    always_comb begin
        rdata = '0;
        case (paddr_i)
            REG_A:      rdata = pack_pair(job.a0, job.a1);
            REG_B:      rdata = pack_pair(job.b0, job.b1);
            REG_W:      rdata = pack_pair(job.w0, job.w1);
            REG_ZETA:   rdata = pack_pair(job.zeta, '0);
            REG_CTRL:   rdata[CTRL_ACC] = job.accumulate;
            REG_STATUS: begin
                rdata[STAT_BUSY] = (state == JOB_BUSY);
                rdata[STAT_DONE] = (state == JOB_DONE);
            end
            REG_RESULT: rdata = pack_pair(c0_q, c1_q);
            default:    rdata = '0;
        endcase
    end

    assign prdata_o = (psel_i && !pwrite_i) ? rdata : '0;

    // access phase always follows a setup phase
    a_penable_psel: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(penable_i) |-> psel_i)
        else $error("pwm_apb_regs penable rose without psel");

endmodule

`default_nettype wire

// File: hdl/karatsuba_pairwm.sv
// karatsuba pairwise multiplier for ML-KEM in the NTT domain
// c0 = a0*b0 + a1*b1*zeta, c1 = (a0+a1)(b0+b1) - a0*b0 - a1*b1, optional +w
// latency is LAT_PLAIN cycles, or LAT_ACC cycles when the job accumulates
`timescale 1ns/10ps
`default_nettype none

module karatsuba_pairwm
    import pwm_pkg::*;
(
    input  wire     clk,
    input  wire     reset_n,
    pwm_job_if.pipe job
);

    // products straight out of the multipliers
    coef_t p00;
    coef_t p11;
    coef_t p_sum;
    coef_t p_zeta;

    // registered adder outputs
    coef_t sum_a;
    coef_t sum_b;
    coef_t kara_0;
    coef_t c1_int;
    coef_t c0_int;
    coef_t c0_acc;
    coef_t c1_acc;
    coef_t c1_q;

    // alignment delay lines, index 0 is one cycle after entry
    coef_t [2:0] p00_dly;
    coef_t [2:0] p11_dly;
    coef_t [2:0] zeta_dly;
    coef_t [3:0] w0_dly;
    coef_t [3:0] w1_dly;

    // job tags travelling with the data
    logic [LAT_ACC-1:0] valid_sr;
    logic [LAT_ACC-1:0] acc_sr;
    logic               leave_plain;
    logic               leave_acc;

    // ------------------------------
    // stage 0
    // ------------------------------
    coef_mult_reduce u_mul_00 (.a_i(job.a0), .b_i(job.b0), .r_o(p00));
    coef_mult_reduce u_mul_11 (.a_i(job.a1), .b_i(job.b1), .r_o(p11));

    // operand sums for the middle karatsuba term
    mod_add_sub u_add_a (
        .clk(clk), .reset_n(reset_n), .zeroize_i(job.zeroize), .sub_i(1'b0),
        .a_i(job.a0), .b_i(job.a1), .r_o(sum_a)
    );
    mod_add_sub u_add_b (
        .clk(clk), .reset_n(reset_n), .zeroize_i(job.zeroize), .sub_i(1'b0),
        .a_i(job.b0), .b_i(job.b1), .r_o(sum_b)
    );

    // ------------------------------
    // stages 1 and 2, middle term
    // ------------------------------
    coef_mult_reduce u_mul_sum (.a_i(sum_a), .b_i(sum_b), .r_o(p_sum));

    // (a0+a1)(b0+b1) - a0*b0
    mod_add_sub u_sub_0 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(job.zeroize), .sub_i(1'b1),
        .a_i(p_sum), .b_i(p00_dly[0]), .r_o(kara_0)
    );
    // then minus a1*b1
    mod_add_sub u_sub_1 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(job.zeroize), .sub_i(1'b1),
        .a_i(kara_0), .b_i(p11_dly[1]), .r_o(c1_int)
    );

    // ------------------------------
    // stage 3, zeta term and c0
    // ------------------------------
    coef_mult_reduce u_mul_zeta (.a_i(p11_dly[2]), .b_i(zeta_dly[2]), .r_o(p_zeta));

    mod_add_sub u_add_c0 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(job.zeroize), .sub_i(1'b0),
        .a_i(p_zeta), .b_i(p00_dly[2]), .r_o(c0_int)
    );

    // ------------------------------
    // stage 4, accumulate
    // ------------------------------
    mod_add_sub u_acc_0 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(job.zeroize), .sub_i(1'b0),
        .a_i(c0_int), .b_i(w0_dly[3]), .r_o(c0_acc)
    );
    mod_add_sub u_acc_1 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(job.zeroize), .sub_i(1'b0),
        .a_i(c1_q), .b_i(w1_dly[3]), .r_o(c1_acc)
    );

    // delay lines and tags, all cleared by zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p00_dly  <= '0;
            p11_dly  <= '0;
            zeta_dly <= '0;
            w0_dly   <= '0;
            w1_dly   <= '0;
            c1_q     <= '0;
            valid_sr <= '0;
            acc_sr   <= '0;
        end else if (job.zeroize) begin
            p00_dly  <= '0;
            p11_dly  <= '0;
            zeta_dly <= '0;
            w0_dly   <= '0;
            w1_dly   <= '0;
            c1_q     <= '0;
            valid_sr <= '0;
            acc_sr   <= '0;
        end else begin
            p00_dly  <= {p00_dly[1:0], p00};
            p11_dly  <= {p11_dly[1:0], p11};
            zeta_dly <= {zeta_dly[1:0], job.zeta};
            w0_dly   <= {w0_dly[2:0], job.w0};
            w1_dly   <= {w1_dly[2:0], job.w1};
            // c1 finishes one stage early, hold it to meet c0
            c1_q     <= c1_int;
            valid_sr <= {valid_sr[LAT_ACC-2:0], job.valid};
            acc_sr   <= {acc_sr[LAT_ACC-2:0], job.valid & job.accumulate};
        end
    end

    // output mux follows the tag of the job that is leaving
    assign leave_plain   = valid_sr[LAT_PLAIN-1] & ~acc_sr[LAT_PLAIN-1];
    assign leave_acc     = valid_sr[LAT_ACC-1] & acc_sr[LAT_ACC-1];
    assign job.res_valid = leave_plain | leave_acc;
    assign job.c0        = leave_acc ? c0_acc : c0_int;
    assign job.c1        = leave_acc ? c1_acc : c1_q;

    // ------------------------------
    // latency checks
    // ------------------------------
    a_lat_plain: assert property (@(posedge clk) disable iff (!reset_n || job.zeroize)
        job.valid && !job.accumulate |-> ##LAT_PLAIN job.res_valid)
        else $error("karatsuba_pairwm plain result missing after %0d cycles", LAT_PLAIN);

    a_lat_acc: assert property (@(posedge clk) disable iff (!reset_n || job.zeroize)
        job.valid && job.accumulate |-> ##LAT_ACC job.res_valid)
        else $error("karatsuba_pairwm accumulated result missing after %0d cycles", LAT_ACC);

    a_no_orphan: assert property (@(posedge clk) disable iff (!reset_n || job.zeroize)
        job.res_valid |-> $past(job.valid && !job.accumulate, LAT_PLAIN) ||
                          $past(job.valid && job.accumulate, LAT_ACC))
        else $error("karatsuba_pairwm res_valid without a matching job");

endmodule

`default_nettype wire

// File: hdl/mod_add_sub.sv
// registered modular adder or subtractor, one cycle of latency
// sub_i selects a-b, otherwise a+b, both taken modulo q
`timescale 1ns/10ps
`default_nettype none

module mod_add_sub
    import pwm_pkg::*;
(
    input  wire        clk,
    input  wire        reset_n,
    input  wire        zeroize_i,
    input  wire        sub_i,
    input  wire coef_t a_i,
    input  wire coef_t b_i,
    output coef_t      r_o
);

    logic [COEF_W:0] sum;
    logic [COEF_W:0] diff;
    coef_t           res;

    always_comb begin
        sum  = {1'b0, a_i} + {1'b0, b_i};
        diff = {1'b0, a_i} - {1'b0, b_i};
        if (sub_i) begin
            // borrow out means a < b, wrap back by adding q
            res = diff[COEF_W] ? coef_t'(diff + MLKEM_Q) : coef_t'(diff);
        end else begin
            res = (sum >= MLKEM_Q) ? coef_t'(sum - MLKEM_Q) : coef_t'(sum);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_o <= '0;
        end else if (zeroize_i) begin
            r_o <= '0;
        end else begin
            r_o <= res;
        end
    end

    // result stays reduced for every downstream stage
    a_res_reduced: assert property (@(posedge clk) disable iff (!reset_n) r_o < MLKEM_Q)
        else $error("mod_add_sub r_o=%h not below q", r_o);

endmodule

`default_nettype wire

// File: hdl/coef_mult_reduce.sv
// combinational coefficient multiplier with barrett reduction modulo q
// one instance per product in the pairwise multiply pipeline
`timescale 1ns/10ps
`default_nettype none

module coef_mult_reduce
    import pwm_pkg::*;
(
    input  wire coef_t a_i,
    input  wire coef_t b_i,
    output coef_t      r_o
);

    prod_t                      prod;
    logic [2*$bits(prod_t)-1:0] prod_scaled;
    logic [COEF_W:0]            quot;
    logic [COEF_W+1:0]          rem;

    always_comb begin
        // plain 12x12 product, below q^2
        prod        = prod_t'(a_i) * prod_t'(b_i);
        // quotient estimate, at most one short of the true quotient
        prod_scaled = prod * BARRETT_M;
        quot        = prod_scaled[BARRETT_K +: COEF_W+1];
        // remainder lands in [0, 2q)
        rem         = (COEF_W+2)'(prod - quot * MLKEM_Q);
        // single correction step
        if (rem >= MLKEM_Q) begin
            r_o = coef_t'(rem - MLKEM_Q);
        end else begin
            r_o = coef_t'(rem);
        end
    end

    // operands reach here only from reduced registers or reduced adders
    always_comb begin
        a_in_range: assert final ($isunknown({a_i, b_i}) ||
                                  (a_i < MLKEM_Q && b_i < MLKEM_Q))
            else $error("coef_mult_reduce operand not reduced a=%h b=%h", a_i, b_i);
    end

endmodule

`default_nettype wire

// File: hdl/pwm_job_if.sv
// job channel between the register file and the pairwise multiply pipeline
// one job is taken per cycle of valid, no stall path exists
`timescale 1ns/10ps
`default_nettype none

interface pwm_job_if
    import pwm_pkg::*;
();

    // request side
    logic  valid;
    logic  zeroize;
    logic  accumulate;
    coef_t a0;
    coef_t a1;
    coef_t b0;
    coef_t b1;
    coef_t w0;
    coef_t w1;
    coef_t zeta;

    // result side, res_valid pulses once per job
    logic  res_valid;
    coef_t c0;
    coef_t c1;

    modport regs (
        output valid, zeroize, accumulate, a0, a1, b0, b1, w0, w1, zeta,
        input  res_valid, c0, c1
    );

    modport pipe (
        input  valid, zeroize, accumulate, a0, a1, b0, b1, w0, w1, zeta,
        output res_valid, c0, c1
    );

endinterface

`default_nettype wire

// File: hdl/pwm_pkg.sv
// shared constants, types and register map for the ML-KEM pairwise multiplier
// modules and the job interface pull this in with a wildcard import
`default_nettype none

package pwm_pkg;

    // ------------------------------
    // arithmetic
    // ------------------------------
    localparam int MLKEM_Q = 3329;
    localparam int COEF_W  = 12;

    // coefficient, held below q everywhere in the datapath
    typedef logic [COEF_W-1:0]   coef_t;
    // full product of two coefficients
    typedef logic [2*COEF_W-1:0] prod_t;

    // barrett constants, m = floor(2^k / q) with k covering the whole product
    localparam int    BARRETT_K = 2 * COEF_W;
    localparam prod_t BARRETT_M = prod_t'((1 << BARRETT_K) / MLKEM_Q);

    // end to end pipeline latency in cycles
    localparam int LAT_PLAIN = 4;
    localparam int LAT_ACC   = 5;

    // ------------------------------
    // apb register map
    // ------------------------------
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t REG_A      = 8'h00;
    localparam apb_addr_t REG_B      = 8'h04;
    localparam apb_addr_t REG_W      = 8'h08;
    localparam apb_addr_t REG_ZETA   = 8'h0C;
    localparam apb_addr_t REG_CTRL   = 8'h10;
    localparam apb_addr_t REG_STATUS = 8'h14;
    localparam apb_addr_t REG_RESULT = 8'h18;

    // element 0 sits at bit 0, element 1 starts here
    localparam int ELEM1_LSB = 16;

    // control and status bit positions
    localparam int CTRL_START = 0;
    localparam int CTRL_ACC   = 1;
    localparam int CTRL_ZERO  = 2;
    localparam int STAT_BUSY  = 0;
    localparam int STAT_DONE  = 1;

endpackage

`default_nettype wire
